// ==== stream_vectors.txt ====
// columns in hex: kind, gap or phase, last or ready mode, pad, 8 data digits
// kind 0 beat, 1 phase (ready 0 low 1 high 2 random, data is capacity base), f end
121000000000
00101234abcd
131000000000
00000000b001
00000000b002
00000000b003
00100000b004
00000000b005
00000000b006
00000000b007
00100000b008
1400c0de0000
152000000000
0200deadbeef
00000000c102
03100000c103
01000000c104
00005a5a0f0f
0500c0ffee06
00100000c107
02000000c108
01100000c109
f00000000000

// ==== compile.f ====
+incdir+.
stream_pkg.sv
stream_stage.sv
fifo_mem.sv
stream_fifo.sv
stream_pipe_top.sv
stream_pipe_asserts.sv
tb_stream_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the stream buffer testbench with Verilator and run it
# the run passes only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_stream_pipe -o sim_stream_pipe \
    || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/sim_stream_pipe)"
echo "$sim_out"

echo "$sim_out" | grep -qx "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb_stream_pipe.sv ====
/*
 * testbench for the stream buffer top level
 * replays vector beats and checks order, latency, throughput and capacity
 */
`timescale 1ns/10ps
`default_nettype none

`include "stream_cfg.svh"

module tb_stream_pipe
    import stream_pkg::*;
();

    localparam int VEC_COUNT  = 64;
    localparam int WAIT_LIMIT = 200;
    localparam int CAPACITY   = (`STREAM_FIFO_FLAGS != 0) ?
                                `STREAM_FIFO_DEPTH + 4 : `STREAM_FIFO_DEPTH + 3;

    // vector kinds, top hex digit of each line
    localparam logic [3:0] KIND_PHASE = 4'h1;
    localparam logic [3:0] KIND_END   = 4'hf;

    // out_ready modes
    localparam logic [3:0] READY_LOW    = 4'h0;
    localparam logic [3:0] READY_HIGH   = 4'h1;

    localparam int PHASE_LATENCY  = 2;
    localparam int PHASE_BURST    = 3;
    localparam int PHASE_CAPACITY = 4;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    stream_beat_t in_beat;
    logic         out_valid;
    logic         out_ready;
    stream_beat_t out_beat;
    logic         fifo_empty;

    logic [47:0]  vec [VEC_COUNT];
    stream_beat_t exp_q [$];
    int           out_times [$];
    int           cycle = 0;
    int           sent_count = 0;
    int           recv_count = 0;
    int           value_errors = 0;
    int           other_errors = 0;
    int           phase;
    int           phase_beats;
    logic [3:0]   ready_mode = READY_LOW;
    logic         timed_out;

    stream_pipe_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .fifo_empty(fifo_empty)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // out_ready driver, random mode flips a coin every cycle
    initial begin
        void'($urandom(98666));
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (ready_mode == READY_LOW) begin
                out_ready <= 1'b0;
            end else if (ready_mode == READY_HIGH) begin
                out_ready <= 1'b1;
            end else begin
                out_ready <= 1'($urandom & 1);
            end
        end
    end

    // scoreboard, input handshakes queue up, output handshakes pop in order
    always @(posedge clk) begin
        stream_beat_t exp;
        if (rst_n) begin
            if (in_valid && in_ready) begin
                exp_q.push_back(in_beat);
                sent_count <= sent_count + 1;
            end
            if (out_valid && out_ready) begin
                recv_count <= recv_count + 1;
                out_times.push_back(cycle);
                assert (exp_q.size() != 0) else begin
                    other_errors++;
                    $display("output beat %h appeared with nothing left to send", out_beat);
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    assert (out_beat.data == exp.data) else begin
                        value_errors++;
                        $display("[ERROR] out_beat.data: got %h, expected %h",
                                 out_beat.data, exp.data);
                    end
                    assert (out_beat.last == exp.last) else begin
                        value_errors++;
                        $display("[ERROR] out_beat.last: got %h, expected %h",
                                 out_beat.last, exp.last);
                    end
                end
            end
        end
    end

    task automatic check_idle(input string when);
        assert (!out_valid) else begin
            value_errors++;
            $display("[ERROR] out_valid %s: got %h, expected %h", when, out_valid, 1'b0);
        end
        assert (fifo_empty) else begin
            value_errors++;
            $display("[ERROR] fifo_empty %s: got %h, expected %h", when, fifo_empty, 1'b1);
        end
        assert (in_ready) else begin
            value_errors++;
            $display("[ERROR] in_ready %s: got %h, expected %h", when, in_ready, 1'b1);
        end
    endtask

    // at least one edge first so a handshake on this edge is counted
    task automatic wait_drained(input string when);
        int n;
        n = 0;
        in_valid <= 1'b0;
        do begin
            @(posedge clk);
            n++;
        end while (sent_count != recv_count && n < WAIT_LIMIT);
        assert (sent_count == recv_count) else begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout %s: %0d beats still in the pipeline after %0d cycles",
                     when, sent_count - recv_count, WAIT_LIMIT);
        end
    endtask

    // returns on the edge of the handshake with in_valid still high
    task automatic send_beat(input stream_beat_t b, input int gap,
                             output int hs_cycle, output int waits);
        if (gap > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        in_beat  <= b;
        in_valid <= 1'b1;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
        end while (!in_ready && waits < WAIT_LIMIT);
        hs_cycle = cycle;
        assert (in_ready) else begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout: beat %h was never accepted on the input", b);
        end
    endtask

    task automatic check_latency(input int hs_cycle);
        int n;
        n = 0;
        in_valid <= 1'b0;
        do begin
            @(posedge clk);
            n++;
        end while (!out_valid && n < WAIT_LIMIT);
        assert (out_valid) else begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout: out_valid never rose after the input handshake");
        end
        if (out_valid) begin
            assert (cycle - hs_cycle == 3) else begin
                other_errors++;
                $display("input to output latency was %0d cycles instead of 3",
                         cycle - hs_cycle);
            end
        end
    endtask

    // fill with out_ready low, count what gets in, then drain
    task automatic run_capacity(input data_word_t base);
        stream_beat_t b;
        int accepted;
        int low_run;
        int n;
        accepted = 0;
        low_run  = 0;
        n        = 0;
        b.data   = base;
        b.last   = 1'b0;
        in_beat  <= b;
        in_valid <= 1'b1;
        while (low_run < 10 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (in_ready) begin
                accepted++;
                low_run = 0;
                b.data  = base + data_word_t'(accepted) * 32'h00010003;
                b.last  = (accepted % 5 == 4);
                in_beat <= b;
            end else begin
                low_run++;
            end
        end
        assert (low_run == 10) else begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout: in_ready never stayed low under back-pressure");
        end
        assert (accepted == CAPACITY) else begin
            other_errors++;
            $display("pipeline took %0d beats under back-pressure instead of %0d",
                     accepted, CAPACITY);
        end
        ready_mode <= READY_HIGH;
        // beat still on offer goes in once the output moves
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!in_ready && n < WAIT_LIMIT);
        assert (in_ready) else begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout: in_ready stayed low after out_ready was released");
        end
        wait_drained("after the capacity fill");
        assert (fifo_empty) else begin
            value_errors++;
            $display("[ERROR] fifo_empty after drain: got %h, expected %h", fifo_empty, 1'b1);
        end
    endtask

    task automatic finish_phase();
        int k;
        wait_drained("at the end of a phase");
        if (phase == PHASE_BURST && !timed_out) begin
            assert (out_times.size() == phase_beats) else begin
                other_errors++;
                $display("burst sent %0d beats but %0d came out",
                         phase_beats, out_times.size());
            end
            for (k = 1; k < out_times.size(); k++) begin
                assert (out_times[k] == out_times[k - 1] + 1) else begin
                    other_errors++;
                    $display("burst output %0d left %0d cycles after the one before",
                             k, out_times[k] - out_times[k - 1]);
                end
            end
        end
    endtask

    task automatic start_phase(input logic [3:0] num, input logic [3:0] mode);
        phase       = int'(num);
        phase_beats = 0;
        out_times.delete();
        ready_mode  <= mode;
        // let the new out_ready reach the DUT
        repeat (2) @(posedge clk);
    endtask

    initial begin
        logic [47:0]  v;
        stream_beat_t b;
        int           idx;
        int           hs;
        int           waits;
        logic         done;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_beat     = '0;
        timed_out   = 1'b0;
        phase       = 1;
        phase_beats = 0;
        $readmemh("stream_vectors.txt", vec);

        repeat (2) @(posedge clk);
        check_idle("during reset");
        rst_n <= 1'b1;
        @(posedge clk);
        check_idle("after reset");

        idx  = 0;
        done = 1'b0;
        while (!done && idx < VEC_COUNT) begin
            v = vec[idx];
            idx++;
            if ($isunknown(v) || v[47:44] == KIND_END) begin
                done = 1'b1;
            end else if (v[47:44] == KIND_PHASE) begin
                finish_phase();
                start_phase(v[43:40], v[39:36]);
                if (phase == PHASE_CAPACITY) begin
                    run_capacity(v[31:0]);
                end
            end else begin
                b.data = v[31:0];
                b.last = v[36];
                send_beat(b, int'(v[43:40]), hs, waits);
                phase_beats++;
                if (phase == PHASE_LATENCY) begin
                    check_latency(hs);
                    wait_drained("after the latency beat");
                end
                if (phase == PHASE_BURST) begin
                    assert (waits == 1) else begin
                        other_errors++;
                        $display("burst beat %0d waited %0d cycles for in_ready",
                                 phase_beats, waits);
                    end
                end
            end
            if (timed_out) begin
                done = 1'b1;
            end
        end
        finish_phase();

        $display("error count: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== stream_pipe_asserts.sv ====
/*
 * handshake and reset checks for the stream buffer top level
 */
`timescale 1ns/10ps
`default_nettype none

module stream_pipe_asserts
    import stream_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         in_ready,
    input logic         mid_valid,
    input logic         mid_ready,
    input stream_beat_t mid_beat,
    input logic         out_valid,
    input logic         out_ready,
    input stream_beat_t out_beat,
    input logic         fifo_empty
);

    // beat stalled between input stage and FIFO holds until taken
    mid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mid_valid && !mid_ready |=> mid_valid && $stable(mid_beat))
        else $error("input stage beat changed or was dropped while the FIFO was full");

    // stalled output beat holds until taken
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("output beat changed or was dropped while out_ready was low");

    // one cycle into reset everything is idle
    reset_idle: assert property (@(posedge clk)
        !rst_n |=> !out_valid && in_ready && fifo_empty)
        else $error("outputs not at their reset values after reset");

endmodule

bind stream_pipe_top stream_pipe_asserts asserts0 (.*);

`default_nettype wire

// ==== stream_pipe_top.sv ====
/*
 * stream buffer top level
 * input skid stage feeding the FIFO and its registered output
 */
`timescale 1ns/10ps
`default_nettype none

`include "stream_cfg.svh"

module stream_pipe_top
    import stream_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // stream in
    input  logic         in_valid,
    output logic         in_ready,
    input  stream_beat_t in_beat,

    // stream out
    output logic         out_valid,
    input  logic         out_ready,
    output stream_beat_t out_beat,

    // FIFO status
    output logic         fifo_empty
);

    // link from the input stage into the FIFO write side
    logic         mid_valid;
    logic         mid_ready;
    stream_beat_t mid_beat;

    // registers the incoming handshake
    stream_stage stage_in (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_beat  (in_beat),
        .out_valid(mid_valid),
        .out_ready(mid_ready),
        .out_beat (mid_beat)
    );

    // storage plus output stage
    stream_fifo #(
        .DEPTH    (`STREAM_FIFO_DEPTH),
        .ADDR_MODE((`STREAM_FIFO_FLAGS != 0) ? fifo_addr_flags : fifo_addr_pointers)
    ) fifo0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (mid_valid),
        .in_ready (mid_ready),
        .in_beat  (mid_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_beat (out_beat),
        .empty    (fifo_empty)
    );

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
/*
 * valid/ready FIFO with a combinational memory and a registered output stage
 * full/empty from pointers or from per-entry valid flags
 */
`timescale 1ns/10ps
`default_nettype none

`include "stream_cfg.svh"

module stream_fifo
    import stream_pkg::*;
#(
    parameter int              DEPTH     = `STREAM_FIFO_DEPTH,
    parameter fifo_addr_mode_t ADDR_MODE = (`STREAM_FIFO_FLAGS != 0) ?
                                           fifo_addr_flags : fifo_addr_pointers
)(
    input  logic         clk,
    input  logic         rst_n,

    // write side
    input  logic         in_valid,
    output logic         in_ready,
    input  stream_beat_t in_beat,

    // registered read side
    output logic         out_valid,
    input  logic         out_ready,
    output stream_beat_t out_beat,

    output logic         empty
);

    // pointer increment with wrap at the last entry
    // keeps depths that are not a power of two working
    function automatic fifo_ptr_t ptr_next(input fifo_ptr_t ptr);
        fifo_ptr_t nxt;
        if (ptr == fifo_ptr_t'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    fifo_ptr_t read_ptr;
    fifo_ptr_t write_ptr;
    logic      full;

    // handshakes on both sides of the memory
    logic wr_fire;
    logic rd_fire;

    // internal read stream, memory to output stage
    logic         rd_valid;
    logic         rd_ready;
    stream_beat_t rd_beat;

    // ready depends on pointer/flag registers only
    assign in_ready = !full;
    assign wr_fire  = in_valid && in_ready;

    // memory output is valid whenever something is stored
    assign rd_valid = !empty;
    assign rd_fire  = rd_valid && rd_ready;

    // read and write pointers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_ptr  <= '0;
            write_ptr <= '0;
        end else begin
            if (wr_fire) begin
                write_ptr <= ptr_next(write_ptr);
            end
            if (rd_fire) begin
                read_ptr <= ptr_next(read_ptr);
            end
        end
    end

    generate
        if (ADDR_MODE == fifo_addr_pointers) begin : g_pointers

            // one entry stays unused so equal pointers always mean empty
            always_comb begin
                empty = (read_ptr == write_ptr);
                full  = (ptr_next(write_ptr) == read_ptr);
            end

        end else begin : g_flags

            // one valid bit per memory entry
            logic [DEPTH-1:0] entry_flags;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    entry_flags <= '0;
                end else begin
                    // never the same entry, a read needs the flag set
                    // and a write needs it clear
                    if (rd_fire) begin
                        entry_flags[read_ptr] <= 1'b0;
                    end
                    if (wr_fire) begin
                        entry_flags[write_ptr] <= 1'b1;
                    end
                end
            end

            // all DEPTH entries usable
            always_comb begin
                empty = !entry_flags[read_ptr];
                full  = entry_flags[write_ptr];
            end

        end
    endgenerate

    fifo_mem #(
        .DEPTH(DEPTH)
    ) mem0 (
        .clk         (clk),
        .write_enable(wr_fire),
        .write_addr  (write_ptr),
        .write_beat  (in_beat),
        .read_addr   (read_ptr),
        .read_beat   (rd_beat)
    );

    // output register stage, beats launch from flops rather than the array
    stream_stage out_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (rd_valid),
        .in_ready (rd_ready),
        .in_beat  (rd_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_beat (out_beat)
    );

endmodule

`default_nettype wire

// ==== fifo_mem.sv ====
/*
 * FIFO storage array
 * synchronous write port, combinational read port
 */
`timescale 1ns/10ps
`default_nettype none

`include "stream_cfg.svh"

module fifo_mem
    import stream_pkg::*;
#(
    parameter int DEPTH = `STREAM_FIFO_DEPTH
)(
    input  logic         clk,

    // write port
    input  logic         write_enable,
    input  fifo_ptr_t    write_addr,
    input  stream_beat_t write_beat,

    // read port, no clock involved
    input  fifo_ptr_t    read_addr,
    output stream_beat_t read_beat
);

    // distributed RAM style array
    // contents are don't-care until written
    stream_beat_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_beat;
        end
    end

    // read data follows the address in the same cycle
    assign read_beat = mem[read_addr];

endmodule

`default_nettype wire

// ==== stream_stage.sv ====
/*
 * registered two-entry skid stage
 * cuts valid and ready paths while keeping one beat per cycle
 */
`timescale 1ns/10ps
`default_nettype none

module stream_stage
    import stream_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // upstream side
    input  logic         in_valid,
    output logic         in_ready,
    input  stream_beat_t in_beat,

    // downstream side
    output logic         out_valid,
    input  logic         out_ready,
    output stream_beat_t out_beat
);

    // spare entry, holds the beat caught during a stall
    stream_beat_t skid_beat;

    // main register frees up this cycle
    logic main_free;

    // in_ready low means the spare entry is occupied
    logic skid_full;

    always_comb begin
        main_free = !out_valid || out_ready;
        skid_full = !in_ready;
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else begin
            if (main_free) begin
                if (skid_full) begin
                    // spare entry moves into main, upstream may resume
                    out_valid <= 1'b1;
                    in_ready  <= 1'b1;
                end else begin
                    // pass straight through, or go idle
                    out_valid <= in_valid;
                end
            end else if (in_valid && in_ready) begin
                // downstream stalled while a beat arrives
                // park it in the spare entry and block upstream
                in_ready <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        // main only changes when it is free, so a stalled beat holds
        if (main_free) begin
            if (skid_full) begin
                out_beat <= skid_beat;
            end else begin
                out_beat <= in_beat;
            end
        end

        // spare tracks the input while it is empty
        // it freezes once in_ready drops
        if (in_ready) begin
            skid_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// ==== stream_pkg.sv ====
/*
 * stream types package
 * beat struct, width typedefs and the FIFO address mode enum
 */
`default_nettype none

package stream_pkg;

    `include "stream_cfg.svh"

    // payload data word
    typedef logic [`STREAM_DATA_WIDTH-1:0] data_word_t;

    // FIFO memory address, log2 of the depth
    typedef logic [$clog2(`STREAM_FIFO_DEPTH)-1:0] fifo_ptr_t;

    // one beat on every stream link
    // data word in the upper bits, last flag in bit 0
    typedef struct packed {
        data_word_t data;
        logic       last;
    } stream_beat_t;

    // how the FIFO tells full from empty
    typedef enum logic {
        fifo_addr_pointers = 1'b0,
        fifo_addr_flags    = 1'b1
    } fifo_addr_mode_t;

endpackage

`default_nettype wire

// ==== stream_cfg.svh ====
/*
 * stream buffer configuration
 * data width, FIFO depth and the default FIFO address mode
 */
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// payload word width in bits
`define STREAM_DATA_WIDTH 32

// number of FIFO memory entries, power of two
`define STREAM_FIFO_DEPTH 16

// default address mode
// 0 selects read/write pointers (capacity DEPTH-1)
// 1 selects per-entry valid flags (capacity DEPTH)
`define STREAM_FIFO_FLAGS 0

`endif
